// File: Bender.yml
package:
  name: eth_udp_node

sources:
  # packages first, then the design bottom up
  - files:
      - hw/net_pkg.sv
      - hw/node_pkg.sv
      - hw/node_cfg_regs.sv
      - hw/payload_fifo.sv
      - hw/udp_tx_framer.sv
      - hw/udp_rx_parser.sv
      - hw/eth_udp_node.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_eth_udp_node.sv

// File: hw/eth_udp_node.sv
`timescale 1ns/1ps

module eth_udp_node #(
  parameter int PAYLOAD_DEPTH = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  // config bus
  input  logic                cfg_we,
  input  node_pkg::reg_addr_t cfg_addr,
  input  node_pkg::reg_data_t cfg_wdata,
  output node_pkg::reg_data_t cfg_rdata,
  // transmit payload
  input  logic [7:0]          tx_d,
  input  logic                tx_v,
  output logic                tx_busy,
  // receive payload
  output logic [7:0]          rx_d,
  output logic                rx_v,
  output logic                rx_done,
  output logic                rx_drop,
  // phy
  output logic [7:0]          phy_tx_d,
  output logic                phy_tx_v,
  input  logic [7:0]          phy_rx_d,
  input  logic                phy_rx_v
);

  node_pkg::node_cfg_t cfg;

  node_cfg_regs i_node_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .rx_done   (rx_done),
    .rx_drop   (rx_drop),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg)
  );

  udp_tx_framer #(
    .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
  ) i_udp_tx_framer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .tx_d     (tx_d),
    .tx_v     (tx_v),
    .tx_busy  (tx_busy),
    .phy_tx_d (phy_tx_d),
    .phy_tx_v (phy_tx_v)
  );

  udp_rx_parser i_udp_rx_parser (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .phy_rx_d (phy_rx_d),
    .phy_rx_v (phy_rx_v),
    .rx_d     (rx_d),
    .rx_v     (rx_v),
    .rx_done  (rx_done),
    .rx_drop  (rx_drop)
  );

endmodule

// File: hw/net_pkg.sv
package net_pkg;

  typedef logic [47:0] mac_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [15:0] port_t;

  localparam int ETH_HDR_BYTES = 14;
  localparam int IP_HDR_BYTES  = 20;
  localparam int UDP_HDR_BYTES = 8;
  localparam int HDR_BYTES     = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  PROTO_UDP      = 8'd17;
  localparam logic [7:0]  IP_TTL         = 8'd64;
  localparam logic [7:0]  IP_VER_IHL     = 8'h45;
  localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;
  localparam mac_t        BCAST_MAC      = 48'hffff_ffff_ffff;

  // first field is the first byte on the wire
  typedef struct packed {
    mac_t        dst_mac;
    mac_t        src_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] id;
    logic [15:0] flags_frag;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] hdr_csum;
    ipv4_t       src_ip;
    ipv4_t       dst_ip;
    port_t       src_port;
    port_t       dst_port;
    logic [15:0] udp_len;
    logic [15:0] udp_csum;
  } hdr_t;

  // the 20 ipv4 header bytes out of a combined header
  function automatic logic [IP_HDR_BYTES*8-1:0] ip_bytes(input hdr_t h);
    return {h.ver_ihl, h.tos, h.total_len, h.id, h.flags_frag,
            h.ttl, h.proto, h.hdr_csum, h.src_ip, h.dst_ip};
  endfunction

  // ones' complement sum of ten 16-bit words, end-around carry folded in
  function automatic logic [15:0] ipv4_csum(input logic [IP_HDR_BYTES*8-1:0] ip);
    logic [19:0] acc;
    acc = '0;
    for (int i = 0; i < IP_HDR_BYTES / 2; i++) begin
      acc = acc + 20'(ip[i*16 +: 16]);
    end
    acc = 20'(acc[15:0]) + 20'(acc[19:16]);
    acc = 20'(acc[15:0]) + 20'(acc[19:16]);
    return acc[15:0];
  endfunction

endpackage

// File: hw/node_cfg_regs.sv
`timescale 1ns/1ps

module node_cfg_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cfg_we,
  input  node_pkg::reg_addr_t cfg_addr,
  input  node_pkg::reg_data_t cfg_wdata,
  input  logic                rx_done,
  input  logic                rx_drop,
  output node_pkg::reg_data_t cfg_rdata,
  output node_pkg::node_cfg_t cfg
);

  node_pkg::node_stat_t stat;

  ////////////////////////////////////////////////////////////
  // address registers and frame counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg  <= '0;
      stat <= '0;
    end else begin
      if (cfg_we) begin
        case (cfg_addr)
          node_pkg::REG_LOC_MAC_HI: cfg.loc_mac[47:32] <= cfg_wdata[15:0];
          node_pkg::REG_LOC_MAC_LO: cfg.loc_mac[31:0]  <= cfg_wdata;
          node_pkg::REG_LOC_IP:     cfg.loc_ip         <= cfg_wdata;
          node_pkg::REG_LOC_PORT:   cfg.loc_port       <= cfg_wdata[15:0];
          node_pkg::REG_REM_MAC_HI: cfg.rem_mac[47:32] <= cfg_wdata[15:0];
          node_pkg::REG_REM_MAC_LO: cfg.rem_mac[31:0]  <= cfg_wdata;
          node_pkg::REG_REM_IP:     cfg.rem_ip         <= cfg_wdata;
          node_pkg::REG_REM_PORT:   cfg.rem_port       <= cfg_wdata[15:0];
          default: ;
        endcase
      end
      // counters stick at all ones
      if (rx_done && (stat.rx_frames != 16'hffff)) begin
        stat.rx_frames <= stat.rx_frames + 16'd1;
      end
      if (rx_drop && (stat.rx_drops != 16'hffff)) begin
        stat.rx_drops <= stat.rx_drops + 16'd1;
      end
    end
  end

  // read mux
  always_comb begin
    case (cfg_addr)
      node_pkg::REG_LOC_MAC_HI: cfg_rdata = {16'h0, cfg.loc_mac[47:32]};
      node_pkg::REG_LOC_MAC_LO: cfg_rdata = cfg.loc_mac[31:0];
      node_pkg::REG_LOC_IP:     cfg_rdata = cfg.loc_ip;
      node_pkg::REG_LOC_PORT:   cfg_rdata = {16'h0, cfg.loc_port};
      node_pkg::REG_REM_MAC_HI: cfg_rdata = {16'h0, cfg.rem_mac[47:32]};
      node_pkg::REG_REM_MAC_LO: cfg_rdata = cfg.rem_mac[31:0];
      node_pkg::REG_REM_IP:     cfg_rdata = cfg.rem_ip;
      node_pkg::REG_REM_PORT:   cfg_rdata = {16'h0, cfg.rem_port};
      node_pkg::REG_STATUS:     cfg_rdata = stat;
      default:                  cfg_rdata = '0;
    endcase
  end

endmodule

// File: hw/node_pkg.sv
package node_pkg;

  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // mac hi holds bits 47:32 in the low half of the word
  localparam reg_addr_t REG_LOC_MAC_HI = 4'd0;
  localparam reg_addr_t REG_LOC_MAC_LO = 4'd1;
  localparam reg_addr_t REG_LOC_IP     = 4'd2;
  localparam reg_addr_t REG_LOC_PORT   = 4'd3;
  localparam reg_addr_t REG_REM_MAC_HI = 4'd4;
  localparam reg_addr_t REG_REM_MAC_LO = 4'd5;
  localparam reg_addr_t REG_REM_IP     = 4'd6;
  localparam reg_addr_t REG_REM_PORT   = 4'd7;
  // read only
  localparam reg_addr_t REG_STATUS     = 4'd8;

  typedef struct packed {
    net_pkg::mac_t  loc_mac;
    net_pkg::ipv4_t loc_ip;
    net_pkg::port_t loc_port;
    net_pkg::mac_t  rem_mac;
    net_pkg::ipv4_t rem_ip;
    net_pkg::port_t rem_port;
  } node_cfg_t;

  // rx_frames lands in the upper half of the status word
  typedef struct packed {
    logic [15:0] rx_frames;
    logic [15:0] rx_drops;
  } node_stat_t;

endpackage

// File: hw/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo #(
  parameter int DEPTH = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic [7:0]                 push_d,
  input  logic                       pop,
  input  logic                       clear,
  output logic [7:0]                 pop_d,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  // full drops the push, empty ignores the pop
  assign do_push = push && !clear && (count != CW'(DEPTH));
  assign do_pop  = pop && !clear && (count != '0);

  // first word fall through
  assign pop_d = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: hw/udp_rx_parser.sv
`timescale 1ns/1ps

module udp_rx_parser (
  input  logic                clk,
  input  logic                rst_n,
  input  node_pkg::node_cfg_t cfg,
  input  logic [7:0]          phy_rx_d,
  input  logic                phy_rx_v,
  output logic [7:0]          rx_d,
  output logic                rx_v,
  output logic                rx_done,
  output logic                rx_drop
);

  localparam int HW = $bits(net_pkg::hdr_t);

  logic [5:0]    cnt;
  logic [HW-9:0] hdr_sr;
  net_pkg::hdr_t hdr_c;
  logic          hdr_last;
  logic          frame_end;
  logic          ok_q;
  logic          eth_ok;
  logic          mac_ok;
  logic          ip_ok;
  logic          csum_ok;
  logic          port_ok;
  logic          hdr_ok;

  // the incoming byte completes the header at byte 41
  assign hdr_c     = {hdr_sr, phy_rx_d};
  assign hdr_last  = phy_rx_v && (cnt == 6'(net_pkg::HDR_BYTES - 1));
  assign frame_end = !phy_rx_v && (cnt != '0);

  ////////////////////////////////////////////////////////////
  // header checks
  ////////////////////////////////////////////////////////////

  assign eth_ok  = (hdr_c.ethertype == net_pkg::ETHERTYPE_IPV4);
  assign mac_ok  = (hdr_c.dst_mac == cfg.loc_mac) || (hdr_c.dst_mac == net_pkg::BCAST_MAC);
  assign ip_ok   = (hdr_c.ver_ihl == net_pkg::IP_VER_IHL) &&
                   (hdr_c.proto == net_pkg::PROTO_UDP) &&
                   (hdr_c.dst_ip == cfg.loc_ip);
  // a good header sums to all ones
  assign csum_ok = (net_pkg::ipv4_csum(net_pkg::ip_bytes(hdr_c)) == 16'hffff);
  assign port_ok = (hdr_c.dst_port == cfg.loc_port);
  assign hdr_ok  = eth_ok && mac_ok && ip_ok && csum_ok && port_ok;

  // header capture and payload delay stage
  always_ff @(posedge clk) begin
    if (phy_rx_v && (cnt != 6'(net_pkg::HDR_BYTES))) begin
      hdr_sr <= hdr_c[HW-9:0];
    end
    rx_d <= phy_rx_d;
  end

  ////////////////////////////////////////////////////////////
  // byte count, verdict and result pulses
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      ok_q    <= 1'b0;
      rx_v    <= 1'b0;
      rx_done <= 1'b0;
      rx_drop <= 1'b0;
    end else begin
      // ok_q only rises once the full header is in
      rx_v    <= phy_rx_v && ok_q;
      rx_done <= frame_end && ok_q;
      rx_drop <= frame_end && !ok_q;
      if (frame_end) begin
        cnt  <= '0;
        ok_q <= 1'b0;
      end else if (phy_rx_v) begin
        if (cnt != 6'(net_pkg::HDR_BYTES)) begin
          cnt <= cnt + 6'd1;
        end
        if (hdr_last) begin
          ok_q <= hdr_ok;
        end
      end
    end
  end

endmodule

// File: hw/udp_tx_framer.sv
`timescale 1ns/1ps

module udp_tx_framer #(
  parameter int PAYLOAD_DEPTH = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  node_pkg::node_cfg_t cfg,
  input  logic [7:0]          tx_d,
  input  logic                tx_v,
  output logic                tx_busy,
  output logic [7:0]          phy_tx_d,
  output logic                phy_tx_v
);

  localparam int CW = $clog2(PAYLOAD_DEPTH + 1);
  localparam int HW = $bits(net_pkg::hdr_t);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_HDR,
    ST_PAY
  } state_t;

  state_t        state;
  logic [5:0]    hdr_idx;
  net_pkg::hdr_t hdr_c;
  logic [HW-1:0] hdr_sr;
  logic          start;
  logic          push;
  logic          pop;
  logic          clear;
  logic [7:0]    pop_d;
  logic [CW-1:0] count;

  // no new frame while the last byte is still on the line
  assign start   = (state == ST_IDLE) && tx_v && !phy_tx_v;
  assign push    = start || ((state == ST_FILL) && tx_v);
  assign pop     = (state == ST_PAY);
  assign clear   = (state == ST_IDLE) && !start;
  assign tx_busy = (state != ST_IDLE) || phy_tx_v;

  payload_fifo #(
    .DEPTH (PAYLOAD_DEPTH)
  ) i_payload_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .push   (push),
    .push_d (tx_d),
    .pop    (pop),
    .clear  (clear),
    .pop_d  (pop_d),
    .count  (count)
  );

  ////////////////////////////////////////////////////////////
  // header build from the fill count
  ////////////////////////////////////////////////////////////

  always_comb begin
    hdr_c            = '0;
    hdr_c.dst_mac    = cfg.rem_mac;
    hdr_c.src_mac    = cfg.loc_mac;
    hdr_c.ethertype  = net_pkg::ETHERTYPE_IPV4;
    hdr_c.ver_ihl    = net_pkg::IP_VER_IHL;
    hdr_c.total_len  = 16'(count) + 16'(net_pkg::IP_HDR_BYTES + net_pkg::UDP_HDR_BYTES);
    hdr_c.flags_frag = net_pkg::IP_FLAGS_DF;
    hdr_c.ttl        = net_pkg::IP_TTL;
    hdr_c.proto      = net_pkg::PROTO_UDP;
    hdr_c.src_ip     = cfg.loc_ip;
    hdr_c.dst_ip     = cfg.rem_ip;
    hdr_c.src_port   = cfg.loc_port;
    hdr_c.dst_port   = cfg.rem_port;
    hdr_c.udp_len    = 16'(count) + 16'(net_pkg::UDP_HDR_BYTES);
    // checksum field is still zero here
    hdr_c.hdr_csum   = ~net_pkg::ipv4_csum(net_pkg::ip_bytes(hdr_c));
  end

  ////////////////////////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      hdr_idx  <= '0;
      phy_tx_v <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          phy_tx_v <= 1'b0;
          if (start) begin
            state <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (!tx_v) begin
            state   <= ST_HDR;
            hdr_idx <= '0;
          end
        end
        ST_HDR: begin
          phy_tx_v <= 1'b1;
          hdr_idx  <= hdr_idx + 6'd1;
          if (hdr_idx == 6'(net_pkg::HDR_BYTES - 1)) begin
            state <= ST_PAY;
          end
        end
        ST_PAY: begin
          phy_tx_v <= 1'b1;
          if (count == CW'(1)) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // header shift register and line byte
  always_ff @(posedge clk) begin
    if ((state == ST_FILL) && !tx_v) begin
      hdr_sr <= hdr_c;
    end else if (state == ST_HDR) begin
      hdr_sr <= hdr_sr << 8;
    end
    if (state == ST_HDR) begin
      phy_tx_d <= hdr_sr[HW-1 -: 8];
    end else if (state == ST_PAY) begin
      phy_tx_d <= pop_d;
    end
  end

endmodule

// File: sources.f
+incdir+include
hw/net_pkg.sv
hw/node_pkg.sv
hw/node_cfg_regs.sv
hw/payload_fifo.sv
hw/udp_tx_framer.sv
hw/udp_rx_parser.sv
hw/eth_udp_node.sv
tb/tb_eth_udp_node.sv

// File: include/tb_frame_util.svh
`ifndef TB_FRAME_UTIL_SVH
`define TB_FRAME_UTIL_SVH

localparam logic [31:0] LFSR_SEED = 32'hdcb0;

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit drawn
function automatic int unsigned rand_bits(ref logic [31:0] s, input int nbits);
  int unsigned r;
  r = 0;
  for (int i = 0; i < nbits; i++) begin
    s = lfsr_step(s);
    r = (r << 1) | s[0];
  end
  return r;
endfunction

// ipv4 checksum field over wire bytes 14 to 33
function automatic logic [15:0] header_csum(input net_pkg::hdr_t h);
  logic [$bits(net_pkg::hdr_t)-1:0] v;
  h.hdr_csum = '0;
  v          = h;
  return ~net_pkg::ipv4_csum(
    v[(net_pkg::HDR_BYTES - net_pkg::ETH_HDR_BYTES) * 8 - 1 -: net_pkg::IP_HDR_BYTES * 8]);
endfunction

// reference header for a payload of len bytes
function automatic net_pkg::hdr_t build_hdr(
  input net_pkg::mac_t  dst_mac,
  input net_pkg::mac_t  src_mac,
  input net_pkg::ipv4_t src_ip,
  input net_pkg::ipv4_t dst_ip,
  input net_pkg::port_t src_port,
  input net_pkg::port_t dst_port,
  input int             len
);
  net_pkg::hdr_t h;
  h            = '0;
  h.dst_mac    = dst_mac;
  h.src_mac    = src_mac;
  h.ethertype  = net_pkg::ETHERTYPE_IPV4;
  h.ver_ihl    = net_pkg::IP_VER_IHL;
  h.total_len  = 16'(len + net_pkg::IP_HDR_BYTES + net_pkg::UDP_HDR_BYTES);
  h.flags_frag = net_pkg::IP_FLAGS_DF;
  h.ttl        = net_pkg::IP_TTL;
  h.proto      = net_pkg::PROTO_UDP;
  h.src_ip     = src_ip;
  h.dst_ip     = dst_ip;
  h.src_port   = src_port;
  h.dst_port   = dst_port;
  h.udp_len    = 16'(len + net_pkg::UDP_HDR_BYTES);
  h.hdr_csum   = header_csum(h);
  return h;
endfunction

// byte i of the header in wire order
function automatic logic [7:0] hdr_byte(input net_pkg::hdr_t h, input int i);
  logic [$bits(net_pkg::hdr_t)-1:0] v;
  v = h;
  return v[(net_pkg::HDR_BYTES - 1 - i) * 8 +: 8];
endfunction

function automatic bit values_match(input string name, input logic [31:0] exp,
                                    input logic [31:0] act);
  if (exp !== act) begin
    $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
    return 1'b0;
  end
  return 1'b1;
endfunction

`endif

// File: tb/tb_eth_udp_node.sv
`timescale 1ns/1ps

module tb_eth_udp_node;

  localparam int PAYLOAD_DEPTH = 64;
  localparam int CLK_NS        = 40;
  localparam int RESET_CYC     = 10;
  localparam int N_TX          = 8;
  localparam int N_RX_OK       = 6;
  localparam int N_RX_DROP     = 10;
  localparam int HDR           = net_pkg::HDR_BYTES;

  // register test, limit frame and two status reads count as one item each
  localparam int N_ITEMS  = N_TX + N_RX_OK + N_RX_DROP + 4;
  // transmit payload crosses the node twice, once filling and once sending
  localparam int ITEM_CYC = 2 * (HDR + PAYLOAD_DEPTH + 20);
  localparam longint WATCH_NS = longint'(N_ITEMS * ITEM_CYC + RESET_CYC) * CLK_NS;

  localparam net_pkg::mac_t  LOC_MAC  = 48'h0200_c0a8_0010;
  localparam net_pkg::mac_t  REM_MAC  = 48'h0200_c0a8_0020;
  localparam net_pkg::ipv4_t LOC_IP   = 32'hc0a8_0010;
  localparam net_pkg::ipv4_t REM_IP   = 32'hc0a8_0020;
  localparam net_pkg::port_t LOC_PORT = 16'h1f90;
  localparam net_pkg::port_t REM_PORT = 16'h2328;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                cfg_we;
  node_pkg::reg_addr_t cfg_addr;
  node_pkg::reg_data_t cfg_wdata;
  node_pkg::reg_data_t cfg_rdata;
  logic [7:0]          tx_d;
  logic                tx_v;
  logic                tx_busy;
  logic [7:0]          rx_d;
  logic                rx_v;
  logic                rx_done;
  logic                rx_drop;
  logic [7:0]          phy_tx_d;
  logic                phy_tx_v;
  logic [7:0]          phy_rx_d;
  logic                phy_rx_v;

  logic [7:0]  pay [$];
  logic [7:0]  cap [$];
  logic [7:0]  frame [$];
  logic [31:0] lfsr;
  logic        last_phy_v;
  int          errs;
  int          errs_at_start;
  int          pass_cnt;
  int          fail_cnt;
  int          done_seen;
  int          drop_seen;
  int          exp_frames;
  int          exp_drops;

  `include "tb_frame_util.svh"

  always #(CLK_NS / 2) clk = ~clk;

  eth_udp_node #(
    .PAYLOAD_DEPTH (PAYLOAD_DEPTH)
  ) i_eth_udp_node (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .tx_d      (tx_d),
    .tx_v      (tx_v),
    .tx_busy   (tx_busy),
    .rx_d      (rx_d),
    .rx_v      (rx_v),
    .rx_done   (rx_done),
    .rx_drop   (rx_drop),
    .phy_tx_d  (phy_tx_d),
    .phy_tx_v  (phy_tx_v),
    .phy_rx_d  (phy_rx_d),
    .phy_rx_v  (phy_rx_v)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (values_match(name, exp, act)) else errs++;
  endtask

  task automatic write_reg(input node_pkg::reg_addr_t a, input node_pkg::reg_data_t d);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  // combinational read data is sampled mid low phase
  task automatic read_reg(input node_pkg::reg_addr_t a, output node_pkg::reg_data_t d);
    @(negedge clk);
    cfg_addr = a;
    #(CLK_NS / 4);
    d = cfg_rdata;
  endtask

  task automatic begin_test();
    errs_at_start = errs;
  endtask

  task automatic end_test(input string name);
    if (errs == errs_at_start) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors", name, errs - errs_at_start);
    end
  endtask

  function automatic string fault_name(input int f);
    case (f)
      0:       return "wrong mac";
      1:       return "wrong ethertype";
      2:       return "wrong ip";
      3:       return "wrong protocol";
      4:       return "wrong port";
      5:       return "bad checksum";
      default: return "short frame";
    endcase
  endfunction

  // sends len payload bytes and captures the frame from phy_tx
  task automatic send_tx_frame(input int len);
    net_pkg::hdr_t h;
    logic [7:0]    exp_b;
    bit            bad;
    int            n;
    int            n_exp;
    pay.delete();
    cap.delete();
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      check_val("tx_busy", (i == 0) ? 0 : 1, tx_busy);
      tx_d = 8'(rand_bits(lfsr, 8));
      tx_v = 1'b1;
      pay.push_back(tx_d);
    end
    @(negedge clk);
    check_val("tx_busy", 1, tx_busy);
    tx_v = 1'b0;
    tx_d = '0;
    // header starts on the second edge after tx_v drops
    @(negedge clk);
    check_val("phy_tx_v", 0, phy_tx_v);
    @(negedge clk);
    check_val("phy_tx_v", 1, phy_tx_v);
    n = 0;
    while (phy_tx_v && (n < 2 * (HDR + PAYLOAD_DEPTH))) begin
      cap.push_back(phy_tx_d);
      n++;
      @(negedge clk);
    end
    n_exp = ((len > PAYLOAD_DEPTH) ? PAYLOAD_DEPTH : len) + HDR;
    check_val("phy_tx_v cycles", n_exp, n);
    h   = build_hdr(REM_MAC, LOC_MAC, LOC_IP, REM_IP, LOC_PORT, REM_PORT, n_exp - HDR);
    bad = 1'b0;
    for (int i = 0; (i < n_exp) && (i < n); i++) begin
      exp_b = (i < HDR) ? hdr_byte(h, i) : pay[i - HDR];
      if (!bad && (cap[i] !== exp_b)) begin
        bad = 1'b1;
        check_val($sformatf("phy_tx_d byte %0d", i), exp_b, cap[i]);
      end
    end
  endtask

  task automatic build_rx_frame(input net_pkg::hdr_t h, input int len);
    frame.delete();
    for (int i = 0; i < HDR; i++) begin
      frame.push_back(hdr_byte(h, i));
    end
    for (int i = 0; i < len; i++) begin
      frame.push_back(8'(rand_bits(lfsr, 8)));
    end
  endtask

  // each byte is checked on rx one cycle after it went in
  task automatic send_rx_frame(input bit ok, input string what);
    int n;
    bit exp_v;
    n = frame.size();
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      if (i > 0) begin
        exp_v = ok && (i - 1 >= HDR);
        check_val("rx_v", exp_v, rx_v);
        if (exp_v) begin
          check_val("rx_d", frame[i - 1], rx_d);
        end
      end
      if (i < n) begin
        phy_rx_d = frame[i];
        phy_rx_v = 1'b1;
      end else begin
        phy_rx_d = '0;
        phy_rx_v = 1'b0;
      end
    end
    @(negedge clk);
    check_val("rx_v", 0, rx_v);
    assert (rx_done === ok) else begin
      $display("%0t %s frame: rx_done pulse %s", $time, what, ok ? "missing" : "unexpected");
      errs++;
    end
    assert (rx_drop === !ok) else begin
      $display("%0t %s frame: rx_drop pulse %s", $time, what, ok ? "unexpected" : "missing");
      errs++;
    end
    @(negedge clk);
    assert (!rx_done && !rx_drop) else begin
      $display("%0t %s frame: result pulse longer than one cycle", $time, what);
      errs++;
    end
  endtask

  task automatic check_status();
    node_pkg::reg_data_t d;
    read_reg(node_pkg::REG_STATUS, d);
    check_val("rx_frames", exp_frames, d[31:16]);
    check_val("rx_drops", exp_drops, d[15:0]);
    check_val("rx_done pulses", exp_frames, done_seen);
    check_val("rx_drop pulses", exp_drops, drop_seen);
  endtask

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_done) begin
        done_seen++;
      end
      if (rx_drop) begin
        drop_seen++;
      end
      if (phy_tx_v) begin
        check_val("tx_busy", 1, tx_busy);
      end
      // busy has to drop on the same edge as phy_tx_v
      if (last_phy_v && !phy_tx_v) begin
        check_val("tx_busy", 0, tx_busy);
      end
    end
    last_phy_v = phy_tx_v;
  end

  initial begin
    #(WATCH_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCH_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    node_pkg::reg_data_t d;
    node_pkg::reg_data_t wd;
    logic [31:0]         exp_rd [9];
    net_pkg::hdr_t       h;
    int                  len;
    int                  fault;
    int                  keep;
    rst_n         = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    tx_d          = '0;
    tx_v          = 1'b0;
    phy_rx_d      = '0;
    phy_rx_v      = 1'b0;
    lfsr          = LFSR_SEED;
    last_phy_v    = 1'b0;
    errs          = 0;
    errs_at_start = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    done_seen     = 0;
    drop_seen     = 0;
    exp_frames    = 0;
    exp_drops     = 0;
    exp_rd = '{{16'h0, LOC_MAC[47:32]}, LOC_MAC[31:0], LOC_IP, {16'h0, LOC_PORT},
               {16'h0, REM_MAC[47:32]}, REM_MAC[31:0], REM_IP, {16'h0, REM_PORT}, 32'h0};
    repeat (RESET_CYC) @(negedge clk);
    rst_n = 1'b1;

    // the register values written here stay as the node config
    begin_test();
    for (int a = 0; a < 9; a++) begin
      read_reg(node_pkg::reg_addr_t'(a), d);
      check_val($sformatf("cfg_rdata reset @%0d", a), 0, d);
    end
    for (int a = 0; a < 9; a++) begin
      wd = (a == 8) ? 32'hffff_ffff : exp_rd[a];
      // junk in the unused upper half of 16-bit registers
      if ((a == 0) || (a == 3) || (a == 4) || (a == 7)) begin
        wd[31:16] = 16'h5a5a;
      end
      write_reg(node_pkg::reg_addr_t'(a), wd);
    end
    for (int a = 0; a < 9; a++) begin
      read_reg(node_pkg::reg_addr_t'(a), d);
      check_val($sformatf("cfg_rdata @%0d", a), exp_rd[a], d);
    end
    end_test("register map");

    begin_test();
    for (int k = 0; k < N_TX; k++) begin
      len = 1 + rand_bits(lfsr, 6);
      send_tx_frame(len);
    end
    end_test("transmit framing");

    // run longer than the buffer
    begin_test();
    send_tx_frame(70);
    if (cap.size() > 17) begin
      check_val("total_len", 92, {cap[16], cap[17]});
    end
    end_test("transmit limit");

    begin_test();
    for (int k = 0; k < N_RX_OK; k++) begin
      len = 1 + rand_bits(lfsr, 6);
      h   = build_hdr((k % 2) ? net_pkg::BCAST_MAC : LOC_MAC, REM_MAC, REM_IP, LOC_IP,
                      REM_PORT, LOC_PORT, len);
      build_rx_frame(h, len);
      send_rx_frame(1'b1, (k % 2) ? "broadcast" : "unicast");
      exp_frames++;
    end
    check_status();
    end_test("receive accept");

    begin_test();
    for (int k = 0; k < N_RX_DROP; k++) begin
      len   = 1 + rand_bits(lfsr, 6);
      // every fault once, then random ones
      fault = (k < 7) ? k : (rand_bits(lfsr, 3) % 7);
      h     = build_hdr(LOC_MAC, REM_MAC, REM_IP, LOC_IP, REM_PORT, LOC_PORT, len);
      case (fault)
        0: h.dst_mac = LOC_MAC ^ 48'h1;
        1: h.ethertype = 16'h86dd;
        2: h = build_hdr(LOC_MAC, REM_MAC, REM_IP, LOC_IP ^ 32'h1, REM_PORT, LOC_PORT, len);
        3: begin
          h.proto    = 8'd6;
          h.hdr_csum = header_csum(h);
        end
        4: h = build_hdr(LOC_MAC, REM_MAC, REM_IP, LOC_IP, REM_PORT, LOC_PORT ^ 16'h1, len);
        5: h.hdr_csum[15:8] = h.hdr_csum[15:8] ^ 8'h5a;
        default: ;
      endcase
      build_rx_frame(h, len);
      if (fault == 6) begin
        keep = 1 + rand_bits(lfsr, 5);
        while (frame.size() > keep) begin
          void'(frame.pop_back());
        end
      end
      send_rx_frame(1'b0, fault_name(fault));
      exp_drops++;
    end
    check_status();
    end_test("receive drop");

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (errs == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
